/* design/write_hier_pkg.sv */
package write_hier_pkg;

    // Levels of the store hierarchy, used as pending vector indices
    typedef enum logic [1:0] {
        LVL_L1  = 2'd0,
        LVL_L2  = 2'd1,
        LVL_MEM = 2'd2
    } level_e;

    // One write lane per level
    localparam int NUM_LEVELS = 3;

endpackage

/* design/lane_state_pkg.sv */
package lane_state_pkg;

    // Per-level machine that is free to issue or holds a blocked write
    typedef enum logic {
        LANE_IDLE    = 1'b0,
        LANE_PENDING = 1'b1
    } lane_state_e;

endpackage

/* design/write_capture.sv */
module write_capture import write_hier_pkg::*; #(
    parameter int ADDRESS_WIDTH = 32,
    parameter int DATA_WIDTH    = 32,
    parameter int OFFSET_WIDTH  = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     proc_enable_wr,
    input  logic [ADDRESS_WIDTH-1:0] proc_address_wr,
    input  logic [DATA_WIDTH-1:0]    proc_data_wr,
    input  logic [OFFSET_WIDTH-1:0]  proc_offset_bits_begin,
    input  logic [OFFSET_WIDTH-1:0]  proc_offset_bits_end,
    input  logic [NUM_LEVELS-1:0]    pending,
    output logic                     accept,
    output logic                     write_busy,
    output logic [DATA_WIDTH-1:0]    live_mask,
    output logic [ADDRESS_WIDTH-1:0] saved_address,
    output logic [DATA_WIDTH-1:0]    saved_data,
    output logic [DATA_WIDTH-1:0]    saved_mask
);

    localparam int NUM_SEGS  = 1 << OFFSET_WIDTH;
    localparam int SEG_WIDTH = DATA_WIDTH / NUM_SEGS;

    // Segment mask from the offsets
    // all-zero offsets keep an all-zero mask, which stands for a whole-word write
    always_comb begin
        live_mask = '0;
        if (proc_offset_bits_begin != '0 || proc_offset_bits_end != '0) begin
            for (int i = 0; i < NUM_SEGS; i++) begin
                if (i >= int'(proc_offset_bits_begin) && i <= int'(proc_offset_bits_end)) begin
                    live_mask[i*SEG_WIDTH +: SEG_WIDTH] = '1;
                end
            end
        end
    end

    // Any level still holding the previous write blocks the processor
    assign write_busy = |pending;
    assign accept     = proc_enable_wr & ~write_busy;

    // Copy of the accepted write for levels that have to wait
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            saved_address <= '0;
            saved_data    <= '0;
            saved_mask    <= '0;
        end else if (accept) begin
            saved_address <= proc_address_wr;
            saved_data    <= proc_data_wr;
            saved_mask    <= live_mask;
        end
    end

endmodule

/* design/level_write_lane.sv */
module level_write_lane import lane_state_pkg::*; #(
    parameter int ADDRESS_WIDTH = 32,
    parameter int DATA_WIDTH    = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     accept,
    input  logic                     buff_full,
    input  logic [ADDRESS_WIDTH-1:0] live_address,
    input  logic [DATA_WIDTH-1:0]    live_data,
    input  logic [DATA_WIDTH-1:0]    live_mask,
    input  logic [ADDRESS_WIDTH-1:0] saved_address,
    input  logic [DATA_WIDTH-1:0]    saved_data,
    input  logic [DATA_WIDTH-1:0]    saved_mask,
    output logic                     pending,
    output logic                     wr_enable,
    output logic [ADDRESS_WIDTH-1:0] wr_address,
    output logic [DATA_WIDTH-1:0]    wr_data,
    output logic [DATA_WIDTH-1:0]    wr_mask
);

    lane_state_e state;
    lane_state_e state_next;
    logic        issue_live;
    logic        issue_saved;

    // Issue straight from the processor, or later from the saved copy
    assign issue_live  = (state == LANE_IDLE) && accept && !buff_full;
    assign issue_saved = (state == LANE_PENDING) && !buff_full;

    always_comb begin
        state_next = state;
        case (state)
            LANE_IDLE: begin
                if (accept && buff_full) begin
                    state_next = LANE_PENDING;
                end
            end
            LANE_PENDING: begin
                if (!buff_full) begin
                    state_next = LANE_IDLE;
                end
            end
            default: state_next = LANE_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= LANE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign pending = (state == LANE_PENDING);

    // Outputs stay zero outside an issue cycle
    always_comb begin
        wr_enable  = issue_live | issue_saved;
        wr_address = '0;
        wr_data    = '0;
        wr_mask    = '0;
        if (issue_live) begin
            wr_address = live_address;
            wr_data    = live_data;
            wr_mask    = live_mask;
        end else if (issue_saved) begin
            wr_address = saved_address;
            wr_data    = saved_data;
            wr_mask    = saved_mask;
        end
    end

endmodule

/* design/write_through_top.sv */
module write_through_top import write_hier_pkg::*; #(
    parameter int ADDRESS_WIDTH = 32,
    parameter int DATA_WIDTH    = 32,
    parameter int OFFSET_WIDTH  = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     proc_enable_wr,
    input  logic [ADDRESS_WIDTH-1:0] proc_address_wr,
    input  logic [DATA_WIDTH-1:0]    proc_data_wr,
    input  logic [OFFSET_WIDTH-1:0]  proc_offset_bits_begin,
    input  logic [OFFSET_WIDTH-1:0]  proc_offset_bits_end,
    input  logic                     buff_l1_full,
    input  logic                     buff_l2_full,
    input  logic                     buff_mem_full,
    output logic                     l1_wr_enable,
    output logic [ADDRESS_WIDTH-1:0] l1_wr_address,
    output logic [DATA_WIDTH-1:0]    l1_wr_data,
    output logic [DATA_WIDTH-1:0]    l1_mask,
    output logic                     l2_wr_enable,
    output logic [ADDRESS_WIDTH-1:0] l2_wr_address,
    output logic [DATA_WIDTH-1:0]    l2_wr_data,
    output logic [DATA_WIDTH-1:0]    l2_mask,
    output logic                     mem_wr_enable,
    output logic [ADDRESS_WIDTH-1:0] mem_wr_address,
    output logic [DATA_WIDTH-1:0]    mem_wr_data,
    output logic [DATA_WIDTH-1:0]    mem_mask,
    output logic                     write_busy
);

    logic                     accept;
    logic [DATA_WIDTH-1:0]    live_mask;
    logic [ADDRESS_WIDTH-1:0] saved_address;
    logic [DATA_WIDTH-1:0]    saved_data;
    logic [DATA_WIDTH-1:0]    saved_mask;
    logic [NUM_LEVELS-1:0]    pending;

    write_capture #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) cap0 (
        .clk                   (clk),
        .rst                   (rst),
        .proc_enable_wr        (proc_enable_wr),
        .proc_address_wr       (proc_address_wr),
        .proc_data_wr          (proc_data_wr),
        .proc_offset_bits_begin(proc_offset_bits_begin),
        .proc_offset_bits_end  (proc_offset_bits_end),
        .pending               (pending),
        .accept                (accept),
        .write_busy            (write_busy),
        .live_mask             (live_mask),
        .saved_address         (saved_address),
        .saved_data            (saved_data),
        .saved_mask            (saved_mask)
    );

    // One lane per level, each with its own full flag
    level_write_lane #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) lane_l1 (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .buff_full    (buff_l1_full),
        .live_address (proc_address_wr),
        .live_data    (proc_data_wr),
        .live_mask    (live_mask),
        .saved_address(saved_address),
        .saved_data   (saved_data),
        .saved_mask   (saved_mask),
        .pending      (pending[LVL_L1]),
        .wr_enable    (l1_wr_enable),
        .wr_address   (l1_wr_address),
        .wr_data      (l1_wr_data),
        .wr_mask      (l1_mask)
    );

    level_write_lane #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) lane_l2 (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .buff_full    (buff_l2_full),
        .live_address (proc_address_wr),
        .live_data    (proc_data_wr),
        .live_mask    (live_mask),
        .saved_address(saved_address),
        .saved_data   (saved_data),
        .saved_mask   (saved_mask),
        .pending      (pending[LVL_L2]),
        .wr_enable    (l2_wr_enable),
        .wr_address   (l2_wr_address),
        .wr_data      (l2_wr_data),
        .wr_mask      (l2_mask)
    );

    level_write_lane #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH)
    ) lane_mem (
        .clk          (clk),
        .rst          (rst),
        .accept       (accept),
        .buff_full    (buff_mem_full),
        .live_address (proc_address_wr),
        .live_data    (proc_data_wr),
        .live_mask    (live_mask),
        .saved_address(saved_address),
        .saved_data   (saved_data),
        .saved_mask   (saved_mask),
        .pending      (pending[LVL_MEM]),
        .wr_enable    (mem_wr_enable),
        .wr_address   (mem_wr_address),
        .wr_data      (mem_wr_data),
        .wr_mask      (mem_mask)
    );

endmodule

/* verification/write_through_chk.sv */
module write_through_chk import write_hier_pkg::*; import lane_state_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input logic                  clk,
    input logic                  rst,
    input logic                  proc_enable_wr,
    input logic                  buff_l1_full,
    input logic                  buff_l2_full,
    input logic                  buff_mem_full,
    input logic                  l1_wr_enable,
    input logic                  l2_wr_enable,
    input logic                  mem_wr_enable,
    input logic [DATA_WIDTH-1:0] l1_mask,
    input logic [DATA_WIDTH-1:0] l2_mask,
    input logic [DATA_WIDTH-1:0] mem_mask,
    input logic                  write_busy,
    input logic [NUM_LEVELS-1:0] pending
);

    lane_state_e l1_state;
    lane_state_e l2_state;
    lane_state_e mem_state;
    logic        accept_seen;

    // A full level waits, and leaves pending once its flag drops
    function automatic lane_state_e lane_next(input lane_state_e cur, input logic acc,
                                              input logic full);
        if (cur == LANE_IDLE) begin
            return (acc && full) ? LANE_PENDING : LANE_IDLE;
        end
        return full ? LANE_PENDING : LANE_IDLE;
    endfunction

    assign accept_seen = proc_enable_wr && !write_busy;

    // Expected lane states rebuilt from the strobe and the full flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            l1_state  <= LANE_IDLE;
            l2_state  <= LANE_IDLE;
            mem_state <= LANE_IDLE;
        end else begin
            l1_state  <= lane_next(l1_state, accept_seen, buff_l1_full);
            l2_state  <= lane_next(l2_state, accept_seen, buff_l2_full);
            mem_state <= lane_next(mem_state, accept_seen, buff_mem_full);
        end
    end

    // No level writes while held in reset
    a_l1_reset_quiet: assert property (@(posedge clk) rst |-> !l1_wr_enable)
        else $error("l1 write enable high during reset");
    a_l2_reset_quiet: assert property (@(posedge clk) rst |-> !l2_wr_enable)
        else $error("l2 write enable high during reset");
    a_mem_reset_quiet: assert property (@(posedge clk) rst |-> !mem_wr_enable)
        else $error("mem write enable high during reset");

    // Idle outputs carry no mask
    a_l1_mask_idle: assert property (@(posedge clk) disable iff (rst)
        !l1_wr_enable |-> l1_mask == '0)
        else $error("l1 mask nonzero without a write enable");
    a_l2_mask_idle: assert property (@(posedge clk) disable iff (rst)
        !l2_wr_enable |-> l2_mask == '0)
        else $error("l2 mask nonzero without a write enable");
    a_mem_mask_idle: assert property (@(posedge clk) disable iff (rst)
        !mem_wr_enable |-> mem_mask == '0)
        else $error("mem mask nonzero without a write enable");

    a_busy_lanes: assert property (@(posedge clk) disable iff (rst)
        write_busy == (l1_state == LANE_PENDING || l2_state == LANE_PENDING ||
                       mem_state == LANE_PENDING))
        else $error("write_busy differs from the lane states");

    a_pending_lanes: assert property (@(posedge clk) disable iff (rst)
        pending[LVL_L1] == (l1_state == LANE_PENDING) &&
        pending[LVL_L2] == (l2_state == LANE_PENDING) &&
        pending[LVL_MEM] == (mem_state == LANE_PENDING))
        else $error("pending vector differs from the lane states");

endmodule

bind write_through_top write_through_chk #(.DATA_WIDTH(DATA_WIDTH)) chk0 (
    .clk           (clk),
    .rst           (rst),
    .proc_enable_wr(proc_enable_wr),
    .buff_l1_full  (buff_l1_full),
    .buff_l2_full  (buff_l2_full),
    .buff_mem_full (buff_mem_full),
    .l1_wr_enable  (l1_wr_enable),
    .l2_wr_enable  (l2_wr_enable),
    .mem_wr_enable (mem_wr_enable),
    .l1_mask       (l1_mask),
    .l2_mask       (l2_mask),
    .mem_mask      (mem_mask),
    .write_busy    (write_busy),
    .pending       (pending)
);

/* verification/write_through_tb.sv */
module write_through_tb import write_hier_pkg::*; ();

    localparam int ADDRESS_WIDTH = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int OFFSET_WIDTH  = 2;
    localparam int SEG_WIDTH     = DATA_WIDTH / (1 << OFFSET_WIDTH);
    localparam int MAX_ROWS      = 16;
    localparam int RESET_CYCLES  = 16;
    localparam int MARGIN_CYCLES = 20;

    logic                     clk;
    logic                     rst;
    logic                     proc_enable_wr;
    logic [ADDRESS_WIDTH-1:0] proc_address_wr;
    logic [DATA_WIDTH-1:0]    proc_data_wr;
    logic [OFFSET_WIDTH-1:0]  proc_offset_bits_begin;
    logic [OFFSET_WIDTH-1:0]  proc_offset_bits_end;
    logic [NUM_LEVELS-1:0]    full_v;
    logic [NUM_LEVELS-1:0]    en_v;
    logic [ADDRESS_WIDTH-1:0] addr_v [NUM_LEVELS];
    logic [DATA_WIDTH-1:0]    data_v [NUM_LEVELS];
    logic [DATA_WIDTH-1:0]    mask_v [NUM_LEVELS];
    logic                     write_busy;

    // Stimulus table, one write per row
    string                    row_name        [MAX_ROWS];
    logic [ADDRESS_WIDTH-1:0] row_addr        [MAX_ROWS];
    logic [DATA_WIDTH-1:0]    row_data        [MAX_ROWS];
    logic [OFFSET_WIDTH-1:0]  row_beg         [MAX_ROWS];
    logic [OFFSET_WIDTH-1:0]  row_fin         [MAX_ROWS];
    logic [NUM_LEVELS-1:0]    row_full        [MAX_ROWS];
    int                       row_rel         [MAX_ROWS][NUM_LEVELS];
    logic                     row_busy_strobe [MAX_ROWS];

    int num_rows;
    int cycle_count = 0;
    int cycle_limit;
    int row_errors;
    int tests_passed;
    int tests_failed;

    write_through_top #(
        .ADDRESS_WIDTH(ADDRESS_WIDTH),
        .DATA_WIDTH   (DATA_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) dut0 (
        .clk                   (clk),
        .rst                   (rst),
        .proc_enable_wr        (proc_enable_wr),
        .proc_address_wr       (proc_address_wr),
        .proc_data_wr          (proc_data_wr),
        .proc_offset_bits_begin(proc_offset_bits_begin),
        .proc_offset_bits_end  (proc_offset_bits_end),
        .buff_l1_full          (full_v[LVL_L1]),
        .buff_l2_full          (full_v[LVL_L2]),
        .buff_mem_full         (full_v[LVL_MEM]),
        .l1_wr_enable          (en_v[LVL_L1]),
        .l1_wr_address         (addr_v[LVL_L1]),
        .l1_wr_data            (data_v[LVL_L1]),
        .l1_mask               (mask_v[LVL_L1]),
        .l2_wr_enable          (en_v[LVL_L2]),
        .l2_wr_address         (addr_v[LVL_L2]),
        .l2_wr_data            (data_v[LVL_L2]),
        .l2_mask               (mask_v[LVL_L2]),
        .mem_wr_enable         (en_v[LVL_MEM]),
        .mem_wr_address        (addr_v[LVL_MEM]),
        .mem_wr_data           (data_v[LVL_MEM]),
        .mem_mask              (mask_v[LVL_MEM]),
        .write_busy            (write_busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // Segments from begin to end set
    // Zero offsets mean a whole-word write
    function automatic logic [DATA_WIDTH-1:0] expected_mask(input logic [OFFSET_WIDTH-1:0] beg,
                                                            input logic [OFFSET_WIDTH-1:0] fin);
        logic [DATA_WIDTH-1:0] m;
        int                    seg;
        m = '0;
        if ((beg != '0 || fin != '0) && beg <= fin) begin
            for (int b = 0; b < DATA_WIDTH; b++) begin
                seg = b / SEG_WIDTH;
                if (seg >= int'(beg) && seg <= int'(fin)) begin
                    m[b] = 1'b1;
                end
            end
        end
        return m;
    endfunction

    function automatic string level_name(input int l);
        case (level_e'(l))
            LVL_L1:  return "l1";
            LVL_L2:  return "l2";
            default: return "mem";
        endcase
    endfunction

    // Accept cycle plus one cycle per wait, plus a closing idle cycle
    function automatic int row_cycles(input int r);
        int last;
        last = 1;
        for (int l = 0; l < NUM_LEVELS; l++) begin
            if (row_full[r][l] && row_rel[r][l] + 1 > last) begin
                last = row_rel[r][l] + 1;
            end
        end
        return last + 1;
    endfunction

    task automatic add_row(input string name, input logic [ADDRESS_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] data, input logic rnd,
                           input logic [OFFSET_WIDTH-1:0] beg,
                           input logic [OFFSET_WIDTH-1:0] fin,
                           input logic [NUM_LEVELS-1:0] full, input int rel_l1,
                           input int rel_l2, input int rel_mem, input logic busy_strobe);
        row_name[num_rows]            = name;
        row_addr[num_rows]            = addr;
        row_data[num_rows]            = rnd ? $urandom : data;
        row_beg[num_rows]             = beg;
        row_fin[num_rows]             = fin;
        row_full[num_rows]            = full;
        row_rel[num_rows][LVL_L1]     = rel_l1;
        row_rel[num_rows][LVL_L2]     = rel_l2;
        row_rel[num_rows][LVL_MEM]    = rel_mem;
        row_busy_strobe[num_rows]     = busy_strobe;
        num_rows++;
    endtask

    // Full pattern bits are mem, l2, l1
    // Release cycles count from the accept cycle
    task automatic load_table();
        add_row("no_full_range", 32'h1000_0040, 32'hdead_beef, 1'b0, 2'd1, 2'd2,
                3'b000, 0, 0, 0, 1'b0);
        add_row("no_full_whole_word", 32'h1000_0044, '0, 1'b1, 2'd0, 2'd0,
                3'b000, 0, 0, 0, 1'b0);
        add_row("l1_blocked", 32'h2000_0100, 32'hc0ff_ee01, 1'b0, 2'd0, 2'd3,
                3'b001, 3, 0, 0, 1'b0);
        add_row("l2_blocked", 32'h2000_0104, '0, 1'b1, 2'd1, 2'd3,
                3'b010, 0, 2, 0, 1'b0);
        add_row("mem_blocked", 32'h2000_0108, '0, 1'b1, 2'd2, 2'd2,
                3'b100, 0, 0, 4, 1'b0);
        add_row("all_full_staggered", 32'h3000_0000, 32'ha5a5_5a5a, 1'b0, 2'd0, 2'd2,
                3'b111, 2, 5, 3, 1'b0);
        add_row("all_full_same_release", 32'h3000_0004, '0, 1'b1, 2'd3, 2'd3,
                3'b111, 1, 1, 1, 1'b1);
        add_row("strobe_while_busy", 32'h4000_0010, 32'h1234_5678, 1'b0, 2'd2, 2'd3,
                3'b010, 0, 3, 0, 1'b1);
        add_row("begin_gt_end", 32'h5000_0000, '0, 1'b1, 2'd3, 2'd1,
                3'b000, 0, 0, 0, 1'b0);
        add_row("begin_eq_end", 32'h5000_0004, 32'h8765_4321, 1'b0, 2'd2, 2'd2,
                3'b000, 0, 0, 0, 1'b0);
        add_row("full_range", 32'h5000_0008, '0, 1'b1, 2'd0, 2'd3,
                3'b000, 0, 0, 0, 1'b0);
        add_row("begin_gt_end_blocked", 32'h5000_000c, 32'h0f0f_f0f0, 1'b0, 2'd2, 2'd0,
                3'b001, 2, 0, 0, 1'b0);
    endtask

    task automatic drive_inputs(input logic strobe, input logic [ADDRESS_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] data,
                                input logic [OFFSET_WIDTH-1:0] beg,
                                input logic [OFFSET_WIDTH-1:0] fin,
                                input logic [NUM_LEVELS-1:0] full);
        proc_enable_wr         = strobe;
        proc_address_wr        = addr;
        proc_data_wr           = data;
        proc_offset_bits_begin = beg;
        proc_offset_bits_end   = fin;
        full_v                 = full;
    endtask

    task automatic check_value(input string test, input string what, input int cycle,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: %s in cycle %0d, expected %0h actual %0h",
                     test, what, cycle, expected, actual);
            row_errors++;
        end
    endtask

    task automatic check_level(input int r, input int l, input int k, input logic exp_en,
                               input logic [DATA_WIDTH-1:0] exp_mask);
        logic [ADDRESS_WIDTH-1:0] exp_addr;
        logic [DATA_WIDTH-1:0]    exp_data;
        logic [DATA_WIDTH-1:0]    exp_mask_out;
        string                    lvl;
        lvl          = level_name(l);
        exp_addr     = exp_en ? row_addr[r] : '0;
        exp_data     = exp_en ? row_data[r] : '0;
        exp_mask_out = exp_en ? exp_mask : '0;
        check_value(row_name[r], {lvl, " wr_enable"}, k, 32'(exp_en), 32'(en_v[l]));
        check_value(row_name[r], {lvl, " wr_address"}, k, exp_addr, addr_v[l]);
        check_value(row_name[r], {lvl, " wr_data"}, k, exp_data, data_v[l]);
        check_value(row_name[r], {lvl, " mask"}, k, exp_mask_out, mask_v[l]);
    endtask

    task automatic run_row(input int r);
        logic [DATA_WIDTH-1:0] mask_exp;
        logic [NUM_LEVELS-1:0] full_now;
        logic                  strobe;
        logic                  exp_en;
        logic                  exp_busy;
        int                    last;
        mask_exp   = expected_mask(row_beg[r], row_fin[r]);
        last       = row_cycles(r) - 1;
        row_errors = 0;
        for (int k = 0; k <= last; k++) begin
            @(posedge clk);
            #2;
            if (k == 0) begin
                drive_inputs(1'b1, row_addr[r], row_data[r], row_beg[r], row_fin[r],
                             row_full[r]);
            end else begin
                for (int l = 0; l < NUM_LEVELS; l++) begin
                    full_now[l] = row_full[r][l] && (k < row_rel[r][l]);
                end
                // A second write while busy carries other fields and must be dropped
                strobe = row_busy_strobe[r] && (k == 1);
                if (strobe) begin
                    drive_inputs(1'b1, ~row_addr[r], ~row_data[r], ~row_beg[r],
                                 ~row_fin[r], full_now);
                end else begin
                    drive_inputs(1'b0, '0, '0, '0, '0, full_now);
                end
            end
            #10;
            exp_busy = 1'b0;
            for (int l = 0; l < NUM_LEVELS; l++) begin
                if (k > 0 && row_full[r][l] && k <= row_rel[r][l]) begin
                    exp_busy = 1'b1;
                end
            end
            check_value(row_name[r], "write_busy", k, 32'(exp_busy), 32'(write_busy));
            for (int l = 0; l < NUM_LEVELS; l++) begin
                if (k == 0) begin
                    exp_en = !row_full[r][l];
                end else begin
                    exp_en = row_full[r][l] && (k == row_rel[r][l]);
                end
                check_level(r, l, k, exp_en, mask_exp);
            end
        end
    endtask

    task automatic report_test(input string name);
        if (row_errors == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, row_errors);
        end
    endtask

    initial begin
        void'($urandom(6680));
        rst = 1'b1;
        drive_inputs(1'b0, '0, '0, '0, '0, '0);
        num_rows     = 0;
        row_errors   = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_table();
        cycle_limit = RESET_CYCLES + MARGIN_CYCLES;
        for (int r = 0; r < num_rows; r++) begin
            cycle_limit += row_cycles(r);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        #10;
        check_value("reset_state", "write enables", 0, 32'd0, 32'(en_v));
        check_value("reset_state", "write_busy", 0, 32'd0, 32'(write_busy));
        report_test("reset_state");

        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
            report_test(row_name[r]);
        end
        @(posedge clk);
        #2;
        drive_inputs(1'b0, '0, '0, '0, '0, '0);

        $display("tests %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sources.f */
design/write_hier_pkg.sv
design/lane_state_pkg.sv
design/write_capture.sv
design/level_write_lane.sv
design/write_through_top.sv
verification/write_through_chk.sv
verification/write_through_tb.sv

/* Makefile */
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := write_through_tb
FILE_LIST := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
